// File: sim.f
hw/dmem_map_pkg.sv
hw/dmem_xact_pkg.sv
hw/dmem_decode.sv
hw/d_mem.sv
hw/cr_file.sv
hw/dmem_execute.sv
hw/dmem_result.sv
hw/dmem_port.sv
dv/dmem_chk.sv
dv/dmem_tb.sv

// File: Makefile
OBJ := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module dmem_tb -Mdir $(OBJ) -o dmem_tb_sim
	./$(OBJ)/dmem_tb_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log

// File: dv/dmem_tb.sv
// Self-checking testbench for dmem_port. Core id strap is 1 and only one access is in flight
`timescale 1ns/1ps

module dmem_tb;
    import dmem_xact_pkg::*;

    // Accesses per phase: reset view, data memory, CR writes, per-thread view, filtering
    localparam int n_xact         = 8 + 32 + 32 + 29 + 36;
    localparam int timeout_cycles = n_xact * 8 + 50;
    localparam int n_words        = 8;

    logic        clock;
    logic        reset;
    logic        req;
    dmem_req_t   req_data;
    logic [7:0]  core_id;
    logic        ack;
    logic [31:0] rdata;
    core_cr_t    core_cr;

    // Reference model state
    logic [31:0] mem_model [1024];
    logic [3:0]  pc_en_m;
    logic [3:0]  pc_rst_m;
    logic [31:0] stack_m   [4];
    logic [31:0] tls_m     [4];
    logic [31:0] last_pc_m [4];
    logic [9:0]  pool      [n_words];

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          cycle_count = 0;

    dmem_port DUT (
        .clock    (clock),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .core_id  (core_id),
        .ack      (ack),
        .rdata    (rdata),
        .core_cr  (core_cr)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles, an access never completed", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // Core 0 is the local alias, core 1 the strap
    function automatic logic [7:0] random_core();
        return 8'(random_bits(1));
    endfunction

    function automatic logic [3:0] random_thread();
        return 4'b0001 << random_bits(2);
    endfunction

    function automatic logic [31:0] make_addr(input logic [7:0] core, input logic [1:0] region,
                                              input logic [11:0] low);
        return {core, region, 10'b0, low};
    endfunction

    function automatic logic [1:0] thread_index(input logic [3:0] mask);
        case (mask)
            4'b0001: return 2'd0;
            4'b0010: return 2'd1;
            4'b0100: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    // Returns what a read sees, then applies the access to the model
    task automatic model_access(input logic write, input logic [31:0] addr,
                                input logic [3:0] be, input logic [1:0] tid,
                                input logic [31:0] pc, input logic [31:0] wdata,
                                output logic [31:0] expected);
        logic       hit;
        logic [7:0] off;
        logic [1:0] slot;
        logic [9:0] word;
        hit      = (addr[31:24] == 8'h00) || (addr[31:24] == core_id);
        off      = addr[7:0];
        slot     = addr[3:2];
        word     = addr[11:2];
        expected = '0;
        if (hit && addr[23:22] == 2'd0) begin
            if (!write) begin
                expected = mem_model[word];
            end
            for (int b = 0; b < 4; b++) begin
                if (write && be[b]) begin
                    mem_model[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (hit && addr[23:22] == 2'd1) begin
            if (!write) begin
                case (off)
                    8'h00: expected = {30'b0, tid};
                    8'h04: expected = {24'b0, core_id};
                    8'h08: expected = stack_m[tid];
                    8'h0c: expected = tls_m[tid];
                    8'h10: expected = 32'h0040_0f00;
                    8'h14: expected = 32'd11;
                    8'h20, 8'h24, 8'h28, 8'h2c: expected = last_pc_m[slot];
                    8'h40, 8'h44, 8'h48, 8'h4c: expected = {31'b0, pc_en_m[slot]};
                    8'h50, 8'h54, 8'h58, 8'h5c: expected = {31'b0, pc_rst_m[slot]};
                    8'h60, 8'h64, 8'h68, 8'h6c: expected = stack_m[slot];
                    8'h70, 8'h74, 8'h78, 8'h7c: expected = tls_m[slot];
                    default: expected = '0;
                endcase
            end else begin
                case (off)
                    8'h40, 8'h44, 8'h48, 8'h4c: pc_en_m[slot] = wdata[0];
                    8'h50, 8'h54, 8'h58, 8'h5c: pc_rst_m[slot] = wdata[0];
                    8'h60, 8'h64, 8'h68, 8'h6c: stack_m[slot] = wdata;
                    8'h70, 8'h74, 8'h78, 8'h7c: tls_m[slot] = wdata;
                    default: ;
                endcase
            end
            last_pc_m[tid] = pc;
        end
    endtask

    // One four-phase access with timing, data and status checks
    task automatic run_access(input logic write, input logic [31:0] addr, input logic [3:0] be,
                              input logic [3:0] thread, input logic [31:0] wdata);
        logic [31:0] pc;
        logic [31:0] expected;
        int          edges;
        pc = random_bits(32);
        model_access(write, addr, be, thread_index(thread), pc, wdata, expected);
        req_data.addr    = addr;
        req_data.byteena = be;
        req_data.thread  = thread;
        req_data.pc      = pc;
        req_data.wdata   = wdata;
        req_data.op      = write ? op_write : op_read;
        req   = 1'b1;
        edges = 0;
        do begin
            @(posedge clock);
            #1;
            edges++;
        end while (!ack);
        // Edge 0 counts as the first
        ack_rise: assert (edges == 3)
            else begin
                $display("ack rose %0d cycles after req was first sampled, not 2", edges - 1);
                errors++;
            end
        rdata_ok: assert (rdata == expected)
            else begin
                $display("error rdata: got 0x%08h, expected 0x%08h at addr 0x%08h",
                         rdata, expected, addr);
                errors++;
            end
        req = 1'b0;
        @(posedge clock);
        #1;
        ack_fall: assert (!ack)
            else begin
                $display("ack still high one cycle after req was sampled low");
                errors++;
            end
        core_cr_ok: assert (core_cr == {pc_en_m, pc_rst_m})
            else begin
                $display("error core_cr: got 0x%02h, expected 0x%02h",
                         core_cr, {pc_en_m, pc_rst_m});
                errors++;
            end
        checks += 4;
    endtask

    // All sixteen writable entries, 0x40 to 0x7c
    task automatic readback_cr();
        for (int k = 0; k < 16; k++) begin
            run_access(1'b0, make_addr(random_core(), 2'd1, 12'h040 + 12'(4 * k)), 4'hf,
                       random_thread(), '0);
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [7:0] off;
        lfsr     = 16'd23;
        errors   = 0;
        checks   = 0;
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        core_id  = 8'h01;
        pc_en_m  = 4'hf;
        pc_rst_m = 4'hf;
        for (int i = 0; i < 4; i++) begin
            stack_m[i]   = 32'h0040_0200 + 32'h0000_0200 * 32'(i);
            tls_m[i]     = stack_m[i];
            last_pc_m[i] = '0;
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        // Reset values
        reset_cr: assert (core_cr == 8'hff)
            else begin
                $display("error core_cr: got 0x%02h, expected 0xff after reset", core_cr);
                errors++;
            end
        checks++;
        for (int t = 0; t < 4; t++) begin
            run_access(1'b0, make_addr(random_core(), 2'd1, 12'h060 + 12'(4 * t)), 4'hf,
                       random_thread(), '0);
            run_access(1'b0, make_addr(random_core(), 2'd1, 12'h070 + 12'(4 * t)), 4'hf,
                       random_thread(), '0);
        end

        // Data memory, full words first so that no read sees an unwritten word
        for (int i = 0; i < n_words; i++) begin
            pool[i] = 10'(random_bits(10));
            run_access(1'b1, make_addr(random_core(), 2'd0, {pool[i], 2'b00}), 4'hf,
                       random_thread(), random_bits(32));
        end
        for (int i = 0; i < 2 * n_words; i++) begin
            run_access(1'b1, make_addr(random_core(), 2'd0, {pool[3'(random_bits(3))], 2'b00}),
                       4'(random_bits(4)), random_thread(), random_bits(32));
        end
        for (int i = 0; i < n_words; i++) begin
            run_access(1'b0, make_addr(random_core(), 2'd0, {pool[i], 2'b00}), 4'hf,
                       random_thread(), '0);
        end

        // Control-register writes
        for (int i = 0; i < 16; i++) begin
            off = 8'h40 + 8'(random_bits(4) << 2);
            run_access(1'b1, make_addr(random_core(), 2'd1, {4'h0, off}), 4'hf,
                       random_thread(), random_bits(32));
        end
        readback_cr();

        // Per-thread view
        for (int t = 0; t < 4; t++) begin
            for (int k = 0; k < 6; k++) begin
                run_access(1'b0, make_addr(random_core(), 2'd1, 12'(4 * k)), 4'hf,
                           4'(1 << t), '0);
            end
            off = 8'h20 + 8'(random_bits(2) << 2);
            run_access(1'b0, make_addr(random_core(), 2'd1, {4'h0, off}), 4'hf, 4'(1 << t), '0);
        end
        // Mask that is not one-hot reads as thread 3
        run_access(1'b0, make_addr(8'h01, 2'd1, 12'h000), 4'hf, 4'b0110, '0);

        // ====================
        // Filtering
        // ====================
        for (int i = 0; i < 4; i++) begin
            run_access(1'b1, make_addr(8'h7f, 2'd0, {pool[i], 2'b00}), 4'hf,
                       random_thread(), random_bits(32));
            run_access(1'b1, make_addr(8'h01, 2'(2 + i % 2), {pool[i + 4], 2'b00}), 4'hf,
                       random_thread(), random_bits(32));
        end
        run_access(1'b1, make_addr(8'h03, 2'd1, 12'h060), 4'hf, random_thread(), random_bits(32));
        run_access(1'b1, make_addr(8'h01, 2'd3, 12'h064), 4'hf, random_thread(), random_bits(32));
        run_access(1'b0, make_addr(8'h02, 2'd0, {pool[0], 2'b00}), 4'hf, random_thread(), '0);
        run_access(1'b0, make_addr(8'h01, 2'd2, 12'h060), 4'hf, random_thread(), '0);
        for (int i = 0; i < n_words; i++) begin
            run_access(1'b0, make_addr(random_core(), 2'd0, {pool[i], 2'b00}), 4'hf,
                       random_thread(), '0);
        end
        readback_cr();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/dmem_chk.sv
// Handshake rules on the ack side of dmem_result, checked only while reset is low except the reset rule
`timescale 1ns/1ps

module dmem_chk (
    input logic clock,
    input logic reset,
    input logic req,
    input logic ack
);

    // ====================
    // Handshake rules
    // ====================
    ack_low_in_reset: assert property (@(posedge clock) reset |=> !ack)
        else $error("ack is high after a cycle with reset asserted");

    // Rise is seen one edge late, so req is taken from that edge
    ack_rise_on_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ack_fall_after_req: assert property (@(posedge clock) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

endmodule

bind dmem_result dmem_chk u_chk (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .ack   (ack)
);

// File: hw/dmem_port.sv
// Data-memory port top. One request per handshake, ack rises two cycles after req is first sampled
`timescale 1ns/1ps

module dmem_port (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req,
    input  dmem_xact_pkg::dmem_req_t req_data,
    input  logic [7:0]               core_id,
    output logic                     ack,
    output logic [31:0]              rdata,
    output dmem_xact_pkg::core_cr_t  core_cr
);
    import dmem_xact_pkg::*;

    logic      fire;
    dmem_cmd_t cmd;
    dmem_rsp_t rsp;

    dmem_decode u_decode (
        .clock    (clock),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .core_id  (core_id),
        .fire     (fire),
        .cmd      (cmd)
    );

    dmem_execute u_execute (
        .clock   (clock),
        .reset   (reset),
        .fire    (fire),
        .cmd     (cmd),
        .core_id (core_id),
        .rsp     (rsp),
        .core_cr (core_cr)
    );

    dmem_result u_result (
        .clock (clock),
        .reset (reset),
        .req   (req),
        .rsp   (rsp),
        .ack   (ack),
        .rdata (rdata)
    );

endmodule

// File: hw/dmem_result.sv
// Ack side of the four-phase handshake. rdata holds until the next response
`timescale 1ns/1ps

module dmem_result (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req,
    input  dmem_xact_pkg::dmem_rsp_t rsp,
    output logic                     ack,
    output logic [31:0]              rdata
);

    // Raise on response, drop once req is seen low
    always_ff @(posedge clock) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (rsp.valid) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rsp.valid) begin
            rdata <= rsp.rdata;
        end
    end

endmodule

// File: hw/dmem_execute.sv
// Executes one command per fire pulse. Response is valid one cycle after the access edge
`timescale 1ns/1ps

module dmem_execute (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     fire,
    input  dmem_xact_pkg::dmem_cmd_t cmd,
    input  logic [7:0]               core_id,
    output dmem_xact_pkg::dmem_rsp_t rsp,
    output dmem_xact_pkg::core_cr_t  core_cr
);
    import dmem_xact_pkg::*;

    logic        mem_rd;
    logic        mem_wr;
    logic        cr_rd;
    logic        cr_wr;
    logic [31:0] mem_q;
    logic [31:0] cr_q;
    logic        pending;
    logic        from_mem;
    logic        from_cr;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;

    // Strobes, at most one active
    assign mem_rd = fire && (cmd.op == cmd_mem_rd);
    assign mem_wr = fire && (cmd.op == cmd_mem_wr);
    assign cr_rd  = fire && (cmd.op == cmd_cr_rd);
    assign cr_wr  = fire && (cmd.op == cmd_cr_wr);

    d_mem u_d_mem (
        .clock   (clock),
        .addr    (cmd.word),
        .byteena (cmd.byteena),
        .wdata   (cmd.wdata),
        .rden    (mem_rd),
        .wren    (mem_wr),
        .q       (mem_q)
    );

    cr_file u_cr_file (
        .clock   (clock),
        .reset   (reset),
        .wr      (cr_wr),
        .rd      (cr_rd),
        .offset  (cmd.cr_offset),
        .wdata   (cmd.wdata),
        .thread  (cmd.thread_id),
        .pc      (cmd.pc),
        .core_id (core_id),
        .q       (cr_q),
        .core_cr (core_cr)
    );

    // Remember the read source for the data stage
    always_ff @(posedge clock) begin
        if (reset) begin
            pending   <= 1'b0;
            from_mem  <= 1'b0;
            from_cr   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            pending   <= fire;
            from_mem  <= mem_rd;
            from_cr   <= cr_rd;
            rsp_valid <= pending;
        end
    end

    // Writes and drops answer with zero
    always_ff @(posedge clock) begin
        if (pending) begin
            rsp_rdata <= from_mem ? mem_q : (from_cr ? cr_q : 32'b0);
        end
    end

    assign rsp = '{valid: rsp_valid, rdata: rsp_rdata};

endmodule

// File: hw/cr_file.sv
// Control registers of one core. Last PC per thread is captured only on control-register accesses
`timescale 1ns/1ps

module cr_file (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [7:0]              offset,
    input  logic [31:0]             wdata,
    input  logic [1:0]              thread,
    input  logic [31:0]             pc,
    input  logic [7:0]              core_id,
    output logic [31:0]             q,
    output dmem_xact_pkg::core_cr_t core_cr
);
    import dmem_map_pkg::*;

    logic [31:0] stack_base [4];
    logic [31:0] tls_base   [4];
    logic [31:0] last_pc    [4];
    logic [1:0]  slot;
    logic [3:0]  pc_en_we;
    logic [3:0]  pc_rst_we;
    logic [3:0]  stk_we;
    logic [3:0]  tls_we;

    // Per-thread entries sit 4 bytes apart
    assign slot = offset[3:2];

    // ====================
    // Write decode
    // ====================
    always_comb begin
        pc_en_we  = '0;
        pc_rst_we = '0;
        stk_we    = '0;
        tls_we    = '0;
        if (wr) begin
            case (offset)
                cr_thread0_pc_en, cr_thread1_pc_en,
                cr_thread2_pc_en, cr_thread3_pc_en:           pc_en_we[slot] = 1'b1;
                cr_thread0_pc_rst, cr_thread1_pc_rst,
                cr_thread2_pc_rst, cr_thread3_pc_rst:         pc_rst_we[slot] = 1'b1;
                cr_thread0_stack_base, cr_thread1_stack_base,
                cr_thread2_stack_base, cr_thread3_stack_base: stk_we[slot] = 1'b1;
                cr_thread0_tls_base, cr_thread1_tls_base,
                cr_thread2_tls_base, cr_thread3_tls_base:     tls_we[slot] = 1'b1;
                default: ;
            endcase
        end
    end

    // ====================
    // Storage
    // ====================
    always_ff @(posedge clock) begin
        if (reset) begin
            core_cr.pc_en  <= '1;
            core_cr.pc_rst <= '1;
            for (int i = 0; i < 4; i++) begin
                stack_base[i] <= stack_reset_base + stack_reset_step * 32'(i);
                tls_base[i]   <= stack_reset_base + stack_reset_step * 32'(i);
                last_pc[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (pc_en_we[i])  core_cr.pc_en[i]  <= wdata[0];
                if (pc_rst_we[i]) core_cr.pc_rst[i] <= wdata[0];
                if (stk_we[i])    stack_base[i]     <= wdata;
                if (tls_we[i])    tls_base[i]       <= wdata;
            end
            if (rd || wr) begin
                last_pc[thread] <= pc;
            end
        end
    end

    // Registered read, sees the state before this access
    always_ff @(posedge clock) begin
        if (rd) begin
            case (offset)
                cr_thread_id:   q <= {30'b0, thread};
                cr_core_id:     q <= {24'b0, core_id};
                cr_stack_base:  q <= stack_base[thread];
                cr_tls_base:    q <= tls_base[thread];
                cr_shared_base: q <= shared_base;
                cr_d_mem_msb:   q <= 32'(msb_d_mem);
                cr_thread0_pc, cr_thread1_pc,
                cr_thread2_pc, cr_thread3_pc:                 q <= last_pc[slot];
                cr_thread0_pc_en, cr_thread1_pc_en,
                cr_thread2_pc_en, cr_thread3_pc_en:           q <= {31'b0, core_cr.pc_en[slot]};
                cr_thread0_pc_rst, cr_thread1_pc_rst,
                cr_thread2_pc_rst, cr_thread3_pc_rst:         q <= {31'b0, core_cr.pc_rst[slot]};
                cr_thread0_stack_base, cr_thread1_stack_base,
                cr_thread2_stack_base, cr_thread3_stack_base: q <= stack_base[slot];
                cr_thread0_tls_base, cr_thread1_tls_base,
                cr_thread2_tls_base, cr_thread3_tls_base:     q <= tls_base[slot];
                default:        q <= '0;
            endcase
        end
    end

endmodule

// File: hw/d_mem.sv
// Behavioral 1024 x 32 data SRAM. Contents are undefined until written and q holds until the next read
`timescale 1ns/1ps

module d_mem (
    input  logic        clock,
    input  logic [9:0]  addr,
    input  logic [3:0]  byteena,
    input  logic [31:0] wdata,
    input  logic        rden,
    input  logic        wren,
    output logic [31:0] q
);

    logic [31:0] mem [1024];

    always_ff @(posedge clock) begin
        // Byte lane merge
        if (wren) begin
            for (int b = 0; b < 4; b++) begin
                if (byteena[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        // Synchronous read, old data on a same-cycle write
        if (rden) begin
            q <= mem[addr];
        end
    end

endmodule

// File: hw/dmem_decode.sv
// Accepts one request per four-phase handshake. A thread mask that is not one-hot is taken as thread 3
`timescale 1ns/1ps

module dmem_decode (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req,
    input  dmem_xact_pkg::dmem_req_t req_data,
    input  logic [7:0]               core_id,
    output logic                     fire,
    output dmem_xact_pkg::dmem_cmd_t cmd
);
    import dmem_map_pkg::*;
    import dmem_xact_pkg::*;

    hs_state_e  state;
    logic       local_core;
    logic [1:0] region;

    // ====================
    // Handshake FSM
    // ====================
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= hs_idle;
        end else begin
            case (state)
                hs_idle: if (req) state <= hs_busy;
                hs_busy: if (!req) state <= hs_idle;
            endcase
        end
    end

    // Single pulse, only the idle cycle that sees req
    assign fire = (state == hs_idle) && req;

    // ====================
    // Address and thread decode
    // ====================
    always_comb begin
        local_core = (req_data.addr[core_id_msb:core_id_lsb] == 8'h00) ||
                     (req_data.addr[core_id_msb:core_id_lsb] == core_id);
        region     = req_data.addr[region_msb:region_lsb];

        cmd.op = cmd_drop;
        if (local_core && region == d_mem_region) begin
            cmd.op = (req_data.op == op_write) ? cmd_mem_wr : cmd_mem_rd;
        end else if (local_core && region == cr_region) begin
            cmd.op = (req_data.op == op_write) ? cmd_cr_wr : cmd_cr_rd;
        end

        cmd.word      = req_data.addr[msb_d_mem:2];
        cmd.cr_offset = req_data.addr[msb_cr:0];
        cmd.byteena   = req_data.byteena;
        cmd.wdata     = req_data.wdata;
        cmd.pc        = req_data.pc;

        case (req_data.thread)
            4'b0001: cmd.thread_id = 2'd0;
            4'b0010: cmd.thread_id = 2'd1;
            4'b0100: cmd.thread_id = 2'd2;
            default: cmd.thread_id = 2'd3;
        endcase
    end

endmodule

// File: hw/dmem_xact_pkg.sv
// Transaction types of the data-memory port. One outstanding request at a time, four threads
package dmem_xact_pkg;

    typedef enum logic {
        op_read,
        op_write
    } req_op_e;

    // Request as presented by the core
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  byteena;
        logic [3:0]  thread;
        logic [31:0] pc;
        logic [31:0] wdata;
        req_op_e     op;
    } dmem_req_t;

    typedef enum logic [2:0] {
        cmd_mem_rd,
        cmd_mem_wr,
        cmd_cr_rd,
        cmd_cr_wr,
        cmd_drop
    } dmem_cmd_e;

    // Decoded command, one target only
    typedef struct packed {
        dmem_cmd_e   op;
        logic [9:0]  word;
        logic [7:0]  cr_offset;
        logic [3:0]  byteena;
        logic [31:0] wdata;
        logic [1:0]  thread_id;
        logic [31:0] pc;
    } dmem_cmd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } dmem_rsp_t;

    // Per-thread status bits towards the fetch logic
    typedef struct packed {
        logic [3:0] pc_en;
        logic [3:0] pc_rst;
    } core_cr_t;

    typedef enum logic {
        hs_idle,
        hs_busy
    } hs_state_e;

endpackage

// File: hw/dmem_map_pkg.sv
// Address map of one core. Core id 0 always aliases the local core and region values 2 and 3 are unmapped
package dmem_map_pkg;

    // ====================
    // Address fields
    // ====================
    localparam int core_id_msb = 31;
    localparam int core_id_lsb = 24;
    localparam int region_msb  = 23;
    localparam int region_lsb  = 22;

    localparam logic [1:0] d_mem_region = 2'd0;
    localparam logic [1:0] cr_region    = 2'd1;

    // 4 KB data memory, 256 bytes of control space
    localparam int msb_d_mem = 11;
    localparam int msb_cr    = 7;

    // ====================
    // Reset map
    // ====================
    localparam logic [31:0] shared_base      = 32'h0040_0f00;
    // Thread n starts at stack_reset_base + n * stack_reset_step
    localparam logic [31:0] stack_reset_base = 32'h0040_0200;
    localparam logic [31:0] stack_reset_step = 32'h0000_0200;

    // Control register byte offsets
    typedef enum logic [7:0] {
        cr_thread_id          = 8'h00,
        cr_core_id            = 8'h04,
        cr_stack_base         = 8'h08,
        cr_tls_base           = 8'h0c,
        cr_shared_base        = 8'h10,
        cr_d_mem_msb          = 8'h14,
        cr_thread0_pc         = 8'h20,
        cr_thread1_pc         = 8'h24,
        cr_thread2_pc         = 8'h28,
        cr_thread3_pc         = 8'h2c,
        cr_thread0_pc_en      = 8'h40,
        cr_thread1_pc_en      = 8'h44,
        cr_thread2_pc_en      = 8'h48,
        cr_thread3_pc_en      = 8'h4c,
        cr_thread0_pc_rst     = 8'h50,
        cr_thread1_pc_rst     = 8'h54,
        cr_thread2_pc_rst     = 8'h58,
        cr_thread3_pc_rst     = 8'h5c,
        cr_thread0_stack_base = 8'h60,
        cr_thread1_stack_base = 8'h64,
        cr_thread2_stack_base = 8'h68,
        cr_thread3_stack_base = 8'h6c,
        cr_thread0_tls_base   = 8'h70,
        cr_thread1_tls_base   = 8'h74,
        cr_thread2_tls_base   = 8'h78,
        cr_thread3_tls_base   = 8'h7c
    } cr_addr_e;

endpackage
